// File: flip_correct.f
+incdir+hw
+incdir+dv
hw/flip_pkg.sv
hw/window_if.sv
hw/flag_window_buffer.sv
hw/lowest_energy_flag_locater.sv
hw/wide_subframe_flip_bit_locator.sv
hw/flip_bit_corrector.sv
hw/flip_correct_top.sv
dv/tb_flip_correct.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flip_correct.f \
    --top-module tb_flip_correct -Mdir obj_dir \
    || { echo "Verilator build failed"; exit 1; }

sim_output=$(./obj_dir/Vtb_flip_correct)
echo "$sim_output"
echo "$sim_output" | grep -qxF "Simulation finished: PASS" \
    && exit 0 \
    || exit 1

// File: dv/flip_ref_model.svh
`ifndef FLIP_REF_MODEL_SVH
`define FLIP_REF_MODEL_SVH

// One correction window, indexed by window entry.
typedef flag_t win_flag_t [`FLIP_WINDOW];
typedef ener_t win_ener_t [`FLIP_WINDOW];

// Bit j of the mask stands for offset j above the flag position.
function automatic logic [2:0] offset_mask(input flag_t flag);
    case (flag)
        3'd1: return 3'b101;
        3'd2: return 3'b111;
        3'd3: return 3'b011;
        3'd4: return 3'b010;
        default: return 3'b000;
    endcase
endfunction

// Entry of the lowest-energy nonzero flag in one slice, or -1 for an empty slice.
function automatic int slice_winner(input win_flag_t f, input win_ener_t e, input int first);
    int best;

    best = -1;
    for (int p = first; p < first + `FLIP_WIDTH; p++) begin
        if (f[p] != '0) begin
            if (best < 0 || e[p] < e[best]) begin
                best = p; // Strictly lower, so ties keep the earlier entry.
            end
        end
    end
    return best;
endfunction

function automatic logic [`FLIP_WIDTH-1:0] expected_word(
    input logic [`FLIP_WIDTH-1:0] bits,
    input win_flag_t              f,
    input win_ener_t              e
);
    int                     blk [2];
    int                     red [2];
    int                     bs;
    int                     rs;
    logic [2:0]             mask;
    logic [`FLIP_WINDOW-1:0] flips;

    blk[0] = slice_winner(f, e, 0);
    blk[1] = slice_winner(f, e, `FLIP_WIDTH);
    red[0] = slice_winner(f, e, `FLIP_SUBFRAME);
    red[1] = slice_winner(f, e, `FLIP_WIDTH + `FLIP_SUBFRAME);
    flips  = '0;
    for (int p = `FLIP_WIDTH - `FLIP_PATTERN_DEPTH; p < 2 * `FLIP_WIDTH; p++) begin
        bs = p / `FLIP_WIDTH;
        rs = (p - `FLIP_SUBFRAME) / `FLIP_WIDTH;
        if (f[p] != '0 && blk[bs] == p && red[rs] == p) begin
            mask = offset_mask(f[p]);
            for (int j = 0; j < `FLIP_PATTERN_DEPTH; j++) begin
                if (mask[j] && p + j < 2 * `FLIP_WIDTH) begin
                    flips[p + j] = 1'b1;
                end
            end
        end
    end
    return bits ^ flips[2*`FLIP_WIDTH-1:`FLIP_WIDTH];
endfunction

`endif

// File: dv/tb_flip_correct.sv
`default_nettype none

`include "flip_defs.svh"

module tb_flip_correct import flip_pkg::*; ();

    localparam int NumRows     = 40;
    localparam int NumDirected = 17;
    localparam int WaitLimit   = 200;

    logic                   clk;
    logic                   rst;
    logic                   in_valid;
    logic                   in_ready;
    logic [`FLIP_WIDTH-1:0] in_bits;
    flag_t                  in_flags [`FLIP_WIDTH];
    ener_t                  in_ener  [`FLIP_WIDTH];
    logic                   out_valid;
    logic                   out_ready;
    logic [`FLIP_WIDTH-1:0] out_bits;

    // Stimulus table with its expected column.
    logic [`FLIP_WIDTH-1:0] row_bits   [NumRows];
    flag_t                  row_flags  [NumRows][`FLIP_WIDTH];
    ener_t                  row_ener   [NumRows][`FLIP_WIDTH];
    logic [`FLIP_WIDTH-1:0] row_expect [NumRows];

    int seed  = 81171;
    int n_acc = 0;
    int n_out = 0;

    `include "flip_ref_model.svh"

    flip_correct_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_bits   (in_bits),
        .in_flags  (in_flags),
        .in_ener   (in_ener),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bits  (out_bits)
    );

    task automatic abort_run(input string reason);
        $display("ERROR at time %0t: %s", $time, reason);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s is %0h, expected %0h",
                     $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    endtask

    // Flag-free entries get random energies, which the DUT has to ignore.
    task automatic set_row(input int r, input logic [`FLIP_WIDTH-1:0] bits,
                           input int p0, input int f0, input int e0,
                           input int p1, input int f1, input int e1);
        row_bits[r] = bits;
        for (int i = 0; i < `FLIP_WIDTH; i++) begin
            row_flags[r][i] = '0;
            row_ener[r][i]  = ener_t'($unsigned($random(seed)));
        end
        if (f0 != 0) begin
            row_flags[r][p0] = flag_t'(f0);
            row_ener[r][p0]  = ener_t'(e0);
        end
        if (f1 != 0) begin
            row_flags[r][p1] = flag_t'(f1);
            row_ener[r][p1]  = ener_t'(e1);
        end
    endtask

    // Output k sees words k-1, k and the low half of k+1.
    task automatic build_expected();
        win_flag_t f;
        win_ener_t e;

        for (int k = 0; k < NumRows - 1; k++) begin
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                f[i] = '0;
                e[i] = '0;
                if (k > 0) begin
                    f[i] = row_flags[k - 1][i];
                    e[i] = row_ener[k - 1][i];
                end
                f[`FLIP_WIDTH + i] = row_flags[k][i];
                e[`FLIP_WIDTH + i] = row_ener[k][i];
            end
            for (int i = 0; i < `FLIP_SUBFRAME; i++) begin
                f[2 * `FLIP_WIDTH + i] = row_flags[k + 1][i];
                e[2 * `FLIP_WIDTH + i] = row_ener[k + 1][i];
            end
            row_expect[k] = expected_word(row_bits[k], f, e);
        end
    endtask

    // Called on a rising edge; returns on the edge where the word is taken.
    task automatic send_row(input int r);
        int waited;

        in_valid <= 1'b1;
        in_bits  <= row_bits[r];
        for (int i = 0; i < `FLIP_WIDTH; i++) begin
            in_flags[i] <= row_flags[r][i];
            in_ener[i]  <= row_ener[r][i];
        end
        waited = 0;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            if (waited > WaitLimit) begin
                abort_run($sformatf("in_ready stayed low while offering row %0d", r));
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        out_ready = 1'b0;
        forever begin
            @(posedge clk);
            if (rst) begin
                out_ready <= 1'b0;
            end else begin
                out_ready <= ($unsigned($random(seed)) % 4) != 0; // Stalls about one cycle in four.
            end
        end
    end

    // Handshakes are sampled mid-cycle, away from the edges that change them.
    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid && n_acc < n_out + 2) begin
                abort_run("out_valid rose before the successor of the word was accepted");
            end
            if (out_valid && out_ready) begin
                if (n_out >= NumRows - 1) begin
                    abort_run("an output word appeared after the last expected word");
                end
                compare_value("out_bits", 32'(out_bits), 32'(row_expect[n_out]));
                n_out++;
            end
            if (in_valid && in_ready) begin
                n_acc++;
            end
        end
    end

    initial begin
        int waited;
        int pos_a;
        int pos_b;

        rst      = 1'b1;
        in_valid = 1'b0;
        in_bits  = '0;
        for (int i = 0; i < `FLIP_WIDTH; i++) begin
            in_flags[i] = '0;
            in_ener[i]  = '0;
        end

        set_row(0,  16'h1234, 0, 0, 0, 0, 0, 0);
        set_row(1,  16'hA5A5, 0, 0, 0, 0, 0, 0);
        set_row(2,  16'h0F0F, 3, 1, 100, 0, 0, 0);
        set_row(3,  16'h0000, 6, 2, 50, 0, 0, 0);
        set_row(4,  16'hFFFF, 5, 3, 20, 0, 0, 0);
        set_row(5,  16'h5555, 0, 4, 7, 0, 0, 0);
        set_row(6,  16'h00FF, 15, 1, 30, 0, 0, 0);    // Reaches into the next word.
        set_row(7,  16'h8001, 0, 0, 0, 0, 0, 0);
        set_row(8,  16'h3C3C, 14, 2, 40, 0, 0, 0);    // Last flip falls off the word.
        set_row(9,  16'h0000, 0, 0, 0, 0, 0, 0);
        set_row(10, 16'h7E81, 2, 1, 90, 10, 3, 40);
        set_row(11, 16'h0000, 0, 0, 0, 0, 0, 0);
        set_row(12, 16'hC3C3, 4, 4, 60, 12, 2, 60);   // Equal energies.
        set_row(13, 16'h0000, 0, 0, 0, 0, 0, 0);
        set_row(14, 16'h1111, 12, 2, 200, 0, 0, 0);
        set_row(15, 16'h2222, 2, 1, 10, 0, 0, 0);     // Takes the red slice from row 14.
        set_row(16, 16'h0000, 0, 0, 0, 0, 0, 0);
        for (int r = NumDirected; r < NumRows - 1; r++) begin
            pos_a = int'($unsigned($random(seed)) % `FLIP_WIDTH);
            pos_b = int'($unsigned($random(seed)) % `FLIP_WIDTH);
            set_row(r, `FLIP_WIDTH'($random(seed)),
                    pos_a, 1 + int'($unsigned($random(seed)) % 4),
                    int'($unsigned($random(seed)) % 1024),
                    pos_b, 1 + int'($unsigned($random(seed)) % 4),
                    int'($unsigned($random(seed)) % 1024));
        end
        set_row(NumRows - 1, 16'h0000, 0, 0, 0, 0, 0, 0); // Pushes the last real word out.
        build_expected();

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("out_valid", 32'(out_valid), 0);
        @(posedge clk);

        for (int r = 0; r < NumRows; r++) begin
            send_row(r);
        end
        in_valid <= 1'b0;

        waited = 0;
        while (n_out < NumRows - 1) begin
            waited++;
            if (waited > WaitLimit) begin
                abort_run("timed out waiting for the remaining output words");
            end
            @(posedge clk);
        end

        // The padding word stays behind, so no further word may follow the last one.
        @(negedge clk);
        compare_value("out_valid", 32'(out_valid), 0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/flip_correct_top.sv
`default_nettype none

`include "flip_defs.svh"

module flip_correct_top import flip_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`FLIP_WIDTH-1:0] in_bits,
    input  flag_t                  in_flags [`FLIP_WIDTH],
    input  ener_t                  in_ener  [`FLIP_WIDTH],

    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`FLIP_WIDTH-1:0] out_bits
);

    window_if win_i ();

    // Stage one builds the window, stage two corrects and holds the output word.
    flag_window_buffer buffer_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_bits  (in_bits),
        .in_flags (in_flags),
        .in_ener  (in_ener),
        .win      (win_i.producer)
    );

    flip_bit_corrector corrector_i (
        .clk       (clk),
        .rst       (rst),
        .win       (win_i.consumer),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_bits  (out_bits)
    );

endmodule

`default_nettype wire

// File: hw/flip_bit_corrector.sv
`default_nettype none

`include "flip_defs.svh"

module flip_bit_corrector (
    input  logic                   clk,
    input  logic                   rst,
    window_if.consumer             win,
    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [`FLIP_WIDTH-1:0] out_bits
);

    logic [`FLIP_WIDTH-1:0] flip_bits;
    logic                   take;

    wide_subframe_flip_bit_locator locator_i (
        .flags     (win.flags),
        .flag_ener (win.ener),
        .flip_bits (flip_bits)
    );

    // The output register frees up in the same cycle it is read.
    assign win.ready = !out_valid || out_ready;
    assign take      = win.valid && win.ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (win.ready) begin
            out_valid <= win.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_bits <= win.bits ^ flip_bits; // Corrected word n-1.
        end
    end

endmodule

`default_nettype wire

// File: hw/wide_subframe_flip_bit_locator.sv
`default_nettype none

`include "flip_defs.svh"

module wide_subframe_flip_bit_locator import flip_pkg::*; (
    input  flag_t                  flags     [`FLIP_WINDOW],
    input  ener_t                  flag_ener [`FLIP_WINDOW],
    output logic [`FLIP_WIDTH-1:0] flip_bits
);

    // Lowest flag position that can still reach the current word.
    localparam int FirstReach = `FLIP_WIDTH - `FLIP_PATTERN_DEPTH + 1;

    flag_t blk_flags [2][`FLIP_WIDTH];
    ener_t blk_ener  [2][`FLIP_WIDTH];
    flag_t blk_best  [2][`FLIP_WIDTH];
    flag_t red_flags [2][`FLIP_WIDTH];
    ener_t red_ener  [2][`FLIP_WIDTH];
    flag_t red_best  [2][`FLIP_WIDTH];

    // Slice winners placed back on window entry numbers.
    flag_t blk_win [0:2*`FLIP_WIDTH-1];
    flag_t red_win [`FLIP_SUBFRAME:`FLIP_WINDOW-1];

    flag_t sel_flags [FirstReach:2*`FLIP_WIDTH-1];

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                blk_flags[s][i] = flags[s * `FLIP_WIDTH + i];
                blk_ener[s][i]  = flag_ener[s * `FLIP_WIDTH + i];
                red_flags[s][i] = flags[`FLIP_SUBFRAME + s * `FLIP_WIDTH + i];
                red_ener[s][i]  = flag_ener[`FLIP_SUBFRAME + s * `FLIP_WIDTH + i];
            end
        end
    end

    // Black slices sit on word boundaries, red slices are shifted by one subframe.
    for (genvar g = 0; g < 2; g++) begin : g_slice
        lowest_energy_flag_locater blk_loc_i (
            .flags     (blk_flags[g]),
            .flag_ener (blk_ener[g]),
            .best_flag (blk_best[g])
        );

        lowest_energy_flag_locater red_loc_i (
            .flags     (red_flags[g]),
            .flag_ener (red_ener[g]),
            .best_flag (red_best[g])
        );
    end

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                blk_win[s * `FLIP_WIDTH + i]                  = blk_best[s][i];
                red_win[`FLIP_SUBFRAME + s * `FLIP_WIDTH + i] = red_best[s][i];
            end
        end
    end

    // A flag acts only when it won both the black and the red slice it falls in.
    always_comb begin
        for (int p = FirstReach; p < 2 * `FLIP_WIDTH; p++) begin
            if (blk_win[p] == red_win[p]) begin
                sel_flags[p] = blk_win[p];
            end else begin
                sel_flags[p] = '0;
            end
        end
    end

    // Each bit of word n-1 gathers the flips of every flag up to DEPTH-1 places below it.
    // Flips past entry 31 have no bit to land on and drop out here.
    always_comb begin
        pattern_t pat;

        for (int b = 0; b < `FLIP_WIDTH; b++) begin
            flip_bits[b] = 1'b0;
            for (int j = 0; j < `FLIP_PATTERN_DEPTH; j++) begin
                pat          = pattern_bits(sel_flags[`FLIP_WIDTH + b - j]);
                flip_bits[b] = flip_bits[b] | pat[j];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/lowest_energy_flag_locater.sv
`default_nettype none

`include "flip_defs.svh"

module lowest_energy_flag_locater import flip_pkg::*; (
    input  flag_t flags     [`FLIP_WIDTH],
    input  ener_t flag_ener [`FLIP_WIDTH],
    output flag_t best_flag [`FLIP_WIDTH]
);

    logic  found;
    int    best_idx;
    ener_t best_ener;

    always_comb begin
        found     = 1'b0;
        best_idx  = 0;
        best_ener = '0;
        // Strict compare keeps the lowest index when energies tie.
        for (int i = 0; i < `FLIP_WIDTH; i++) begin
            if (flags[i] != '0 && (!found || flag_ener[i] < best_ener)) begin
                found     = 1'b1;
                best_idx  = i;
                best_ener = flag_ener[i];
            end
        end
    end

    // Only the winning entry keeps its flag.
    always_comb begin
        for (int i = 0; i < `FLIP_WIDTH; i++) begin
            if (found && best_idx == i) begin
                best_flag[i] = flags[i];
            end else begin
                best_flag[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/flag_window_buffer.sv
`default_nettype none

`include "flip_defs.svh"

module flag_window_buffer import flip_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [`FLIP_WIDTH-1:0] in_bits,
    input  flag_t                  in_flags [`FLIP_WIDTH],
    input  ener_t                  in_ener  [`FLIP_WIDTH],
    window_if.producer             win
);

    // Full copy of the newest word. Only its low subframe is visible in the window.
    flag_t                  last_flags [`FLIP_WIDTH];
    ener_t                  last_ener  [`FLIP_WIDTH];
    logic [`FLIP_WIDTH-1:0] last_bits;

    logic primed; // Set once a first word sits in the history.
    logic accept;

    // The window register doubles as history, so it may shift once its content has left.
    assign in_ready = !win.valid || win.ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            win.valid <= 1'b0;
            primed    <= 1'b0;
        end else if (accept) begin
            win.valid <= primed; // The first word has no successor yet.
            primed    <= 1'b1;
        end else if (win.ready) begin
            win.valid <= 1'b0;
        end
    end

    // History starts out as zero flags, energies and bits.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `FLIP_WINDOW; i++) begin
                win.flags[i] <= '0;
                win.ener[i]  <= '0;
            end
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                last_flags[i] <= '0;
                last_ener[i]  <= '0;
            end
            win.bits  <= '0;
            last_bits <= '0;
        end else if (accept) begin
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                // Word n-1 moves down to n-2, the stored newest word becomes n-1.
                win.flags[i]               <= win.flags[i + `FLIP_WIDTH];
                win.ener[i]                <= win.ener[i + `FLIP_WIDTH];
                win.flags[i + `FLIP_WIDTH] <= last_flags[i];
                win.ener[i + `FLIP_WIDTH]  <= last_ener[i];
            end
            for (int i = 0; i < `FLIP_SUBFRAME; i++) begin
                win.flags[i + 2 * `FLIP_WIDTH] <= in_flags[i];
                win.ener[i + 2 * `FLIP_WIDTH]  <= in_ener[i];
            end
            for (int i = 0; i < `FLIP_WIDTH; i++) begin
                last_flags[i] <= in_flags[i];
                last_ener[i]  <= in_ener[i];
            end
            win.bits  <= last_bits;
            last_bits <= in_bits;
        end
    end

endmodule

`default_nettype wire

// File: hw/window_if.sv
`default_nettype none

`include "flip_defs.svh"

interface window_if import flip_pkg::*; ();

    logic                   valid;
    logic                   ready;
    logic [`FLIP_WIDTH-1:0] bits;                 // Data of the word being corrected.
    flag_t                  flags [`FLIP_WINDOW];
    ener_t                  ener  [`FLIP_WINDOW];

    // The buffer side presents a window and holds it until ready.
    modport producer (
        output valid,
        output bits,
        output flags,
        output ener,
        input  ready
    );

    modport consumer (
        input  valid,
        input  bits,
        input  flags,
        input  ener,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/flip_pkg.sv
`default_nettype none

`include "flip_defs.svh"

package flip_pkg;

    // Zero means no flag, 1 to FLIP_NUM_PATTERNS select a pattern.
    typedef logic [$clog2(`FLIP_NUM_PATTERNS + 1)-1:0] flag_t;

    typedef logic [`FLIP_ENER_BITS-1:0] ener_t; // Lower energy is more likely.

    typedef logic [`FLIP_PATTERN_DEPTH-1:0] pattern_t;

    // Bit j of an entry flips the bit j places above the flag position.
    localparam pattern_t flip_patterns [`FLIP_NUM_PATTERNS + 1] = '{
        3'b000,
        3'b101,
        3'b111,
        3'b011,
        3'b010
    };

    // Flag codes above the table size flip nothing.
    function automatic pattern_t pattern_bits(flag_t flag);
        if (flag > flag_t'(`FLIP_NUM_PATTERNS)) begin
            return '0;
        end
        return flip_patterns[flag];
    endfunction

endpackage

`default_nettype wire

// File: hw/flip_defs.svh
`ifndef FLIP_DEFS_SVH
`define FLIP_DEFS_SVH

// Bits per data word and flag entries per slice.
`define FLIP_WIDTH 16

// Offset of the red slices against the black ones.
`define FLIP_SUBFRAME 8

`define FLIP_ENER_BITS 10
`define FLIP_NUM_PATTERNS 4
`define FLIP_PATTERN_DEPTH 3

// Two full words of history plus the low subframe of the newest word.
`define FLIP_WINDOW (3 * `FLIP_WIDTH - `FLIP_SUBFRAME)

`endif
